//--- source/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // Register width
    localparam int xlen = 32;

    // Commands from the decoder
    localparam logic [2:0] csr_x     = 3'd0;
    localparam logic [2:0] csr_w     = 3'd1;
    localparam logic [2:0] csr_s     = 3'd2;
    localparam logic [2:0] csr_c     = 3'd3;
    localparam logic [2:0] csr_ecall = 3'd4;
    localparam logic [2:0] csr_mret  = 3'd5;

    // Privilege modes, supervisor not implemented
    localparam logic [1:0] mode_user    = 2'b00;
    localparam logic [1:0] mode_machine = 2'b11;

    // Counters
    localparam logic [11:0] csr_addr_cycle    = 12'hc00;
    localparam logic [11:0] csr_addr_cycleh   = 12'hc80;
    localparam logic [11:0] csr_addr_mcycle   = 12'hb00;
    localparam logic [11:0] csr_addr_mcycleh  = 12'hb80;
    // Machine information and trap setup
    localparam logic [11:0] csr_addr_misa     = 12'h301;
    localparam logic [11:0] csr_addr_mhartid  = 12'hf14;
    localparam logic [11:0] csr_addr_mstatus  = 12'h300;
    localparam logic [11:0] csr_addr_mie      = 12'h304;
    localparam logic [11:0] csr_addr_mtvec    = 12'h305;
    // Machine trap handling
    localparam logic [11:0] csr_addr_mscratch = 12'h340;
    localparam logic [11:0] csr_addr_mepc     = 12'h341;
    localparam logic [11:0] csr_addr_mcause   = 12'h342;
    localparam logic [11:0] csr_addr_mip      = 12'h344;

    // Exception code of ecall from U, M adds the mode on top
    localparam logic [xlen-1:0] cause_ecall_base = 32'd8;
    // Machine timer interrupt code
    localparam logic [xlen-1:0] cause_timer_code = 32'd7;
    // Set in mcause for interrupts
    localparam int cause_interrupt_bit = 31;

    // mstatus fields
    localparam int mstatus_mie_bit    = 3;
    localparam int mstatus_mpie_bit   = 7;
    localparam int mstatus_mpp_lo_bit = 11;
    localparam int mstatus_mpp_hi_bit = 12;
    // mie enables, mip uses the same positions
    localparam int mie_msie_bit = 3;
    localparam int mie_mtie_bit = 7;
    localparam int mie_meie_bit = 11;

    // RV32 with A, I and M
    localparam logic [xlen-1:0] misa_value = 32'h4000_1101;

    // Field view of a CSR address
    typedef struct packed {
        logic [1:0] access;
        logic [1:0] priv;
        logic [7:0] index;
    } csr_addr_fields_t;

    // Raw word for the decode, fields for the privilege check
    typedef union packed {
        logic [11:0]      raw;
        csr_addr_fields_t fields;
    } csr_addr_u;

endpackage

`default_nettype wire

//--- source/csr_state_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_state_if;
    import csr_pkg::*;

    // Current privilege and mstatus trap fields
    logic [1:0]      mode;
    logic            mstatus_mie;
    logic            mstatus_mpie;
    logic [1:0]      mstatus_mpp;
    // Trap handling registers
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    // mtime at or past mtimecmp
    logic            timer_pending;
    // High in the cycle a timer trap is taken
    logic            take_trap;

    modport driver (output mode, mstatus_mie, mstatus_mpie, mstatus_mpp, mepc, mcause,
                    timer_pending, take_trap);
    modport reader (input mode, mstatus_mie, mstatus_mpie, mstatus_mpp, mepc, mcause,
                    timer_pending, take_trap);

endinterface

`default_nettype wire

//--- source/csr_setup_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_setup_if;
    import csr_pkg::*;

    // Trap vector, mode in the low two bits
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mscratch;
    // Interrupt enables
    logic            mie_mtie;
    logic            mie_msie;
    logic            mie_meie;

    modport driver (output mtvec, mscratch, mie_mtie, mie_msie, mie_meie);
    // Full view for the read mux
    modport reader (input mtvec, mscratch, mie_mtie, mie_msie, mie_meie);
    // Trap side needs only the vector and the timer enable
    modport trap (input mtvec, mie_mtie);

endinterface

`default_nettype wire

//--- source/csr_access.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access #(
    parameter logic [csr_pkg::xlen-1:0] hart_id = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [63:0]              cycle,
    input  logic                     branch_hazard,
    input  logic [2:0]               cmd,
    input  logic [csr_pkg::xlen-1:0] op1_data,
    input  logic [csr_pkg::xlen-1:0] imm_i,
    csr_state_if.reader              state,
    csr_setup_if.reader              setup,
    output logic [2:0]               valid_cmd,
    output logic                     trap_ok,
    output logic [csr_pkg::xlen-1:0] rdata,
    output logic                     wr_en,
    output logic [11:0]              wr_addr,
    output logic [csr_pkg::xlen-1:0] wr_data
);
    import csr_pkg::*;

    csr_addr_u       addr_u;
    logic            can_access;
    logic            can_read;
    logic            can_write;
    logic            is_rmw;
    logic [xlen-1:0] mstatus_word;
    logic [xlen-1:0] mie_word;
    logic [xlen-1:0] mip_word;
    logic [xlen-1:0] read_word;

    // Second stage of the read-modify-write
    logic [2:0]      save_cmd;
    logic [11:0]     save_addr;
    logic [xlen-1:0] save_op1;
    logic            save_wr;

    function automatic logic [xlen-1:0] rmw_value(input logic [2:0] op,
                                                  input logic [xlen-1:0] operand,
                                                  input logic [xlen-1:0] old);
        case (op)
            csr_w:   rmw_value = operand;
            csr_s:   rmw_value = old | operand;
            csr_c:   rmw_value = old & ~operand;
            default: rmw_value = '0;
        endcase
    endfunction

    // Hazard turns the slot into a bubble at an unmapped address
    assign valid_cmd  = branch_hazard ? csr_x : cmd;
    assign addr_u.raw = branch_hazard ? 12'hfff : imm_i[11:0];

    // Command is dropped while the timer trap wins the slot
    assign trap_ok = !state.take_trap;

    // Address privilege must not exceed the current mode
    assign can_access = addr_u.fields.priv <= state.mode;
    assign can_read   = can_access;
    // Access field 11 marks read-only registers
    assign can_write  = can_access && (addr_u.fields.access != 2'b11);
    assign is_rmw     = valid_cmd inside {csr_w, csr_s, csr_c};

    always_comb begin
        mstatus_word = '0;
        mstatus_word[mstatus_mie_bit]  = state.mstatus_mie;
        mstatus_word[mstatus_mpie_bit] = state.mstatus_mpie;
        mstatus_word[mstatus_mpp_hi_bit:mstatus_mpp_lo_bit] = state.mstatus_mpp;
        mie_word = '0;
        mie_word[mie_mtie_bit] = setup.mie_mtie;
        mie_word[mie_msie_bit] = setup.mie_msie;
        mie_word[mie_meie_bit] = setup.mie_meie;
        // Only the timer line is pending-capable
        mip_word = '0;
        mip_word[mie_mtie_bit] = state.timer_pending;
    end

    always_comb begin
        case (addr_u.raw)
            csr_addr_cycle, csr_addr_mcycle:   read_word = cycle[31:0];
            csr_addr_cycleh, csr_addr_mcycleh: read_word = cycle[63:32];
            csr_addr_misa:     read_word = misa_value;
            csr_addr_mhartid:  read_word = hart_id;
            csr_addr_mstatus:  read_word = mstatus_word;
            csr_addr_mie:      read_word = mie_word;
            csr_addr_mtvec:    read_word = setup.mtvec;
            csr_addr_mscratch: read_word = setup.mscratch;
            csr_addr_mepc:     read_word = state.mepc;
            csr_addr_mcause:   read_word = state.mcause;
            csr_addr_mip:      read_word = mip_word;
            default:           read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata    <= '0;
            save_cmd <= csr_x;
            save_wr  <= 1'b0;
        end else begin
            // Denied or discarded reads return zero
            rdata    <= (can_read && trap_ok) ? read_word : '0;
            save_cmd <= valid_cmd;
            save_wr  <= is_rmw && can_write && trap_ok;
        end
    end

    // Address and operand ride along with save_cmd
    always_ff @(posedge clk) begin
        save_addr <= addr_u.raw;
        save_op1  <= op1_data;
    end

    // Write lands one edge after the read that fed it
    assign wr_en   = save_wr;
    assign wr_addr = save_addr;
    assign wr_data = rmw_value(save_cmd, save_op1, rdata);

endmodule

`default_nettype wire

//--- source/csr_setup_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_setup_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     wr_en,
    input  logic [11:0]              wr_addr,
    input  logic [csr_pkg::xlen-1:0] wr_data,
    csr_setup_if.driver              setup
);
    import csr_pkg::*;

    logic [xlen-1:0] mscratch_q;
    logic [xlen-1:0] mtvec_q;
    logic            mtie_q;
    logic            msie_q;
    logic            meie_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch_q <= '0;
            mtvec_q    <= '0;
            // Interrupts off out of reset
            mtie_q     <= 1'b0;
            msie_q     <= 1'b0;
            meie_q     <= 1'b0;
        end else if (wr_en) begin
            case (wr_addr)
                csr_addr_mscratch: mscratch_q <= wr_data;
                // Mode bits kept as written
                csr_addr_mtvec:    mtvec_q    <= wr_data;
                csr_addr_mie: begin
                    // Unimplemented enables read back as zero
                    mtie_q <= wr_data[mie_mtie_bit];
                    msie_q <= wr_data[mie_msie_bit];
                    meie_q <= wr_data[mie_meie_bit];
                end
                default: ;
            endcase
        end
    end

    assign setup.mscratch = mscratch_q;
    assign setup.mtvec    = mtvec_q;
    assign setup.mie_mtie = mtie_q;
    assign setup.mie_msie = msie_q;
    assign setup.mie_meie = meie_q;

endmodule

`default_nettype wire

//--- source/csr_trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [63:0]              mtime,
    input  logic [63:0]              mtimecmp,
    input  logic                     interrupt_ready,
    input  logic [csr_pkg::xlen-1:0] fetch_pc,
    input  logic [2:0]               valid_cmd,
    input  logic                     trap_ok,
    input  logic                     wr_en,
    input  logic [11:0]              wr_addr,
    input  logic [csr_pkg::xlen-1:0] wr_data,
    csr_state_if.driver              state,
    csr_setup_if.trap                setup,
    output logic [2:0]               issued_cmd,
    output logic [csr_pkg::xlen-1:0] trap_vector,
    output logic                     stall_may_interrupt
);
    import csr_pkg::*;

    // Interrupt flag plus the timer code
    localparam logic [xlen-1:0] mcause_timer =
        (xlen'(1) << cause_interrupt_bit) | cause_timer_code;

    logic [1:0]      mode;
    logic            mie;
    logic            mpie;
    logic [1:0]      mpp;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic            timer_pending;
    logic            stall;
    logic            take_trap;
    logic [xlen-1:0] direct_target;
    logic [xlen-1:0] timer_target;
    logic [1:0]      wr_mpp;

    assign timer_pending = mtime >= mtimecmp;
    // User mode is always interruptible, machine mode only with MIE
    assign stall = timer_pending && setup.mie_mtie && ((mode == mode_user) || mie);
    assign take_trap = stall && interrupt_ready;
    assign stall_may_interrupt = stall;

    // Base with the mode bits stripped
    assign direct_target = {setup.mtvec[xlen-1:2], 2'b00};
    // Vectored mode offsets by four times the cause
    assign timer_target = (setup.mtvec[1:0] == 2'b01)
                        ? direct_target + (cause_timer_code << 2)
                        : setup.mtvec;

    // Only M and U are legal in MPP
    assign wr_mpp = (wr_data[mstatus_mpp_hi_bit:mstatus_mpp_lo_bit] == mode_machine)
                  ? mode_machine : mode_user;

    always_ff @(posedge clk) begin
        if (rst) begin
            issued_cmd  <= csr_x;
            trap_vector <= '0;
            mode        <= mode_machine;
            mpp         <= mode_machine;
            mie         <= 1'b0;
            mpie        <= 1'b0;
            mepc        <= '0;
            mcause      <= '0;
        end else begin
            // trap_ok low means the timer trap took the slot
            if (!trap_ok) begin
                // Timer trap enters machine mode through the pipeline as an ecall
                issued_cmd  <= csr_ecall;
                mpp         <= mode;
                mode        <= mode_machine;
                mpie        <= mie;
                mie         <= 1'b0;
                mepc        <= fetch_pc;
                mcause      <= mcause_timer;
                trap_vector <= timer_target;
            end else begin
                issued_cmd <= valid_cmd;
                case (valid_cmd)
                    csr_ecall: begin
                        // 8 from U, 11 from M
                        trap_vector <= direct_target;
                        mcause      <= cause_ecall_base + xlen'(mode);
                        mode        <= mode_machine;
                    end
                    csr_mret: begin
                        trap_vector <= mepc;
                        mode        <= mpp;
                        mpp         <= mode_user;
                        mie         <= mpie;
                    end
                    default: ;
                endcase
            end
            // Software writes override the trap updates of the same edge
            if (wr_en) begin
                case (wr_addr)
                    csr_addr_mstatus: begin
                        mie  <= wr_data[mstatus_mie_bit];
                        mpie <= wr_data[mstatus_mpie_bit];
                        mpp  <= wr_mpp;
                    end
                    csr_addr_mepc:   mepc   <= {wr_data[xlen-1:2], 2'b00};
                    csr_addr_mcause: mcause <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    assign state.mode          = mode;
    assign state.mstatus_mie   = mie;
    assign state.mstatus_mpie  = mpie;
    assign state.mstatus_mpp   = mpp;
    assign state.mepc          = mepc;
    assign state.mcause        = mcause;
    assign state.timer_pending = timer_pending;
    assign state.take_trap     = take_trap;

endmodule

`default_nettype wire

//--- source/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter logic [csr_pkg::xlen-1:0] hart_id = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [63:0]              cycle,
    input  logic [63:0]              mtime,
    input  logic [63:0]              mtimecmp,
    input  logic                     branch_hazard,
    input  logic [2:0]               cmd,
    input  logic [csr_pkg::xlen-1:0] op1_data,
    input  logic [csr_pkg::xlen-1:0] imm_i,
    input  logic                     interrupt_ready,
    input  logic [csr_pkg::xlen-1:0] fetch_pc,
    output logic [2:0]               issued_cmd,
    output logic [csr_pkg::xlen-1:0] rdata,
    output logic [csr_pkg::xlen-1:0] trap_vector,
    output logic                     stall_may_interrupt
);
    import csr_pkg::*;

    // Squashed command into the trap side
    logic [2:0]      valid_cmd;
    logic            trap_ok;
    // Write path shared by both register blocks
    logic            wr_en;
    logic [11:0]     wr_addr;
    logic [xlen-1:0] wr_data;

    csr_state_if state_bus ();
    csr_setup_if setup_bus ();

    csr_access #(
        .hart_id (hart_id)
    ) access_i (
        .clk           (clk),
        .rst           (rst),
        .cycle         (cycle),
        .branch_hazard (branch_hazard),
        .cmd           (cmd),
        .op1_data      (op1_data),
        .imm_i         (imm_i),
        .state         (state_bus.reader),
        .setup         (setup_bus.reader),
        .valid_cmd     (valid_cmd),
        .trap_ok       (trap_ok),
        .rdata         (rdata),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data)
    );

    csr_setup_regs setup_regs_i (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .setup   (setup_bus.driver)
    );

    csr_trap_ctrl trap_ctrl_i (
        .clk                 (clk),
        .rst                 (rst),
        .mtime               (mtime),
        .mtimecmp            (mtimecmp),
        .interrupt_ready     (interrupt_ready),
        .fetch_pc            (fetch_pc),
        .valid_cmd           (valid_cmd),
        .trap_ok             (trap_ok),
        .wr_en               (wr_en),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .state               (state_bus.driver),
        .setup               (setup_bus.trap),
        .issued_cmd          (issued_cmd),
        .trap_vector         (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // 4 ns period, starts low
    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule

`default_nettype wire

//--- sim/csr_unit_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_assertions (
    input logic                     clk,
    input logic                     rst,
    input logic                     branch_hazard,
    input logic [2:0]               cmd,
    input logic                     interrupt_ready,
    input logic [2:0]               issued_cmd,
    input logic [csr_pkg::xlen-1:0] rdata,
    input logic [csr_pkg::xlen-1:0] trap_vector,
    input logic                     stall_may_interrupt
);
    import csr_pkg::*;

    // Failures seen so far, read by the testbench at the end
    int fail_count = 0;

    // Outputs leave reset clean and interrupts are off
    reset_state: assert property (@(posedge clk)
        rst |=> (issued_cmd == csr_x && rdata == '0 && trap_vector == '0
                 && !stall_may_interrupt))
    else begin
        fail_count++;
        $error("outputs not at their reset values after rst");
    end

    // Hazard turns the slot into a bubble
    hazard_squash: assert property (@(posedge clk) disable iff (rst)
        branch_hazard && !(stall_may_interrupt && interrupt_ready)
        |=> (issued_cmd == csr_x && rdata == '0))
    else begin
        fail_count++;
        $error("command under branch hazard was not squashed");
    end

    // Without hazard or trap the command passes straight through
    cmd_pass: assert property (@(posedge clk) disable iff (rst)
        !branch_hazard && !(stall_may_interrupt && interrupt_ready)
        |=> issued_cmd == $past(cmd))
    else begin
        fail_count++;
        $error("issued command differs from the command presented");
    end

    // Timer trap wins the slot as an ecall
    trap_issue: assert property (@(posedge clk) disable iff (rst)
        stall_may_interrupt && interrupt_ready
        |=> (issued_cmd == csr_ecall && rdata == '0))
    else begin
        fail_count++;
        $error("timer trap did not issue an ecall");
    end

endmodule

bind csr_unit csr_unit_assertions assertions_i (
    .clk                 (clk),
    .rst                 (rst),
    .branch_hazard       (branch_hazard),
    .cmd                 (cmd),
    .interrupt_ready     (interrupt_ready),
    .issued_cmd          (issued_cmd),
    .rdata               (rdata),
    .trap_vector         (trap_vector),
    .stall_may_interrupt (stall_may_interrupt)
);

`default_nettype wire

//--- sim/csr_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [31:0] tb_hart_id = 32'h0000_0005;
    // About 50 commands at two cycles each, reset and margin
    localparam int cycle_limit = 600;

    logic        clk;
    logic        rst;
    logic [63:0] cycle;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        branch_hazard;
    logic [2:0]  cmd;
    logic [31:0] op1_data;
    logic [31:0] imm_i;
    logic        interrupt_ready;
    logic [31:0] fetch_pc;
    logic [2:0]  issued_cmd;
    logic [31:0] rdata;
    logic [31:0] trap_vector;
    logic        stall_may_interrupt;

    // Expected values armed for the next edge
    logic        check_rd;
    logic        check_iss;
    logic        check_tv;
    logic        check_stall;
    logic [31:0] exp_rd;
    logic [2:0]  exp_iss;
    logic [31:0] exp_tv;
    logic        exp_stall;

    int          mismatch_count = 0;
    int          other_count = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_q = 32'hf463;

    // Shadow of the architectural state
    logic [31:0] sh_mscratch;
    logic [31:0] sh_mtvec;
    logic [31:0] sh_mepc;
    logic [1:0]  sh_mode;

    tb_clock clock_i (.clk(clk));

    csr_unit #(
        .hart_id (tb_hart_id)
    ) dut_i (
        .clk (clk), .rst (rst), .cycle (cycle), .mtime (mtime), .mtimecmp (mtimecmp),
        .branch_hazard (branch_hazard), .cmd (cmd), .op1_data (op1_data), .imm_i (imm_i),
        .interrupt_ready (interrupt_ready), .fetch_pc (fetch_pc),
        .issued_cmd (issued_cmd), .rdata (rdata), .trap_vector (trap_vector),
        .stall_may_interrupt (stall_may_interrupt)
    );

    rd_check: assert property (@(posedge clk) disable iff (rst) check_rd |-> rdata == exp_rd)
    else begin
        mismatch_count++;
        $display("Mismatch rdata: got %h expected %h", $sampled(rdata), $sampled(exp_rd));
    end

    iss_check: assert property (@(posedge clk) disable iff (rst)
        check_iss |-> issued_cmd == exp_iss)
    else begin
        mismatch_count++;
        $display("Mismatch issued_cmd: got %h expected %h",
                 $sampled(issued_cmd), $sampled(exp_iss));
    end

    tv_check: assert property (@(posedge clk) disable iff (rst)
        check_tv |-> trap_vector == exp_tv)
    else begin
        mismatch_count++;
        $display("Mismatch trap_vector: got %h expected %h",
                 $sampled(trap_vector), $sampled(exp_tv));
    end

    stall_check: assert property (@(posedge clk) disable iff (rst)
        check_stall |-> stall_may_interrupt == exp_stall)
    else begin
        mismatch_count++;
        $display("Mismatch stall_may_interrupt: got %h expected %h",
                 $sampled(stall_may_interrupt), $sampled(exp_stall));
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] draw(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic clear_checks;
        @(posedge clk);
        cmd         <= csr_x;
        check_rd    <= 1'b0;
        check_iss   <= 1'b0;
        check_tv    <= 1'b0;
        check_stall <= 1'b0;
    endtask

    // Command slot then one idle slot, results checked at the edge after
    task automatic run_cmd(input logic [2:0] c, input logic [11:0] addr,
                           input logic [31:0] op, input logic haz,
                           input logic chk_rd, input logic [31:0] rd_v,
                           input logic chk_tv, input logic [31:0] tv_v);
        clear_checks;
        cmd           <= c;
        imm_i         <= {20'h0, addr};
        op1_data      <= op;
        branch_hazard <= haz;
        @(posedge clk);
        cmd           <= csr_x;
        branch_hazard <= 1'b0;
        check_rd      <= chk_rd;
        exp_rd        <= rd_v;
        check_iss     <= 1'b1;
        exp_iss       <= haz ? csr_x : c;
        check_tv      <= chk_tv;
        exp_tv        <= tv_v;
    endtask

    // Set with a zero mask reads without changing the register
    task automatic read_expect(input logic [11:0] addr, input logic [31:0] value);
        run_cmd(csr_s, addr, 32'h0, 1'b0, 1'b1, value, 1'b0, 32'h0);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] pc_v;
        logic [2:0]  op;
        int          waited;
        rst = 1'b1;
        cycle = '0;
        mtime = 64'd0;
        mtimecmp = 64'd100;
        branch_hazard = 1'b0;
        cmd = csr_x;
        op1_data = '0;
        imm_i = '0;
        interrupt_ready = 1'b0;
        fetch_pc = '0;
        check_rd = 1'b0;
        check_iss = 1'b0;
        check_tv = 1'b0;
        check_stall = 1'b0;
        exp_rd = '0;
        exp_iss = csr_x;
        exp_tv = '0;
        exp_stall = 1'b0;
        sh_mscratch = '0;
        sh_mtvec = '0;
        sh_mepc = '0;
        sh_mode = mode_machine;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        check_stall <= 1'b1;
        exp_stall <= 1'b0;

        // Random write, set and clear on mscratch
        for (int i = 0; i < 20; i++) begin
            v = draw(2);
            op = (v[1:0] == 2'd1) ? csr_s : (v[1:0] == 2'd2) ? csr_c : csr_w;
            v = draw(32);
            run_cmd(op, csr_addr_mscratch, v, 1'b0, 1'b1, sh_mscratch, 1'b0, 32'h0);
            case (op)
                csr_s:   sh_mscratch = sh_mscratch | v;
                csr_c:   sh_mscratch = sh_mscratch & ~v;
                default: sh_mscratch = v;
            endcase
        end

        // Hazard squash, mscratch must keep its value
        run_cmd(csr_w, csr_addr_mscratch, draw(32), 1'b1, 1'b1, 32'h0, 1'b0, 32'h0);
        read_expect(csr_addr_mscratch, sh_mscratch);

        // Vectored mtvec for the timer case later
        v = draw(30);
        sh_mtvec = {v[29:0], 2'b01};
        run_cmd(csr_w, csr_addr_mtvec, sh_mtvec, 1'b0, 1'b1, 32'h0, 1'b0, 32'h0);
        read_expect(csr_addr_mtvec, sh_mtvec);

        // misa is fixed at RV32 IMA, mhartid reports the parameter
        run_cmd(csr_w, csr_addr_misa, draw(32), 1'b0, 1'b1, 32'h4000_1101, 1'b0, 32'h0);
        read_expect(csr_addr_misa, 32'h4000_1101);
        read_expect(csr_addr_mhartid, tb_hart_id);

        // Ecall from machine mode
        run_cmd(csr_ecall, 12'h000, 32'h0, 1'b0, 1'b0, 32'h0, 1'b1, {sh_mtvec[31:2], 2'b00});
        read_expect(csr_addr_mcause, 32'd8 + 32'(sh_mode));

        // mepc keeps word alignment, mpp goes to user before mret
        v = draw(32);
        run_cmd(csr_w, csr_addr_mepc, v, 1'b0, 1'b1, 32'h0, 1'b0, 32'h0);
        sh_mepc = {v[31:2], 2'b00};
        read_expect(csr_addr_mepc, sh_mepc);
        run_cmd(csr_w, csr_addr_mstatus, 32'h0, 1'b0, 1'b1, 32'h0000_1800, 1'b0, 32'h0);
        run_cmd(csr_mret, 12'h000, 32'h0, 1'b0, 1'b0, 32'h0, 1'b1, sh_mepc);
        sh_mode = mode_user;

        // User mode sees no machine registers but can read cycle
        read_expect(csr_addr_mscratch, 32'h0);
        run_cmd(csr_w, csr_addr_mscratch, draw(32), 1'b0, 1'b1, 32'h0, 1'b0, 32'h0);
        v = draw(32);
        cycle <= {draw(32), v};
        read_expect(csr_addr_cycle, v);

        // Ecall from user mode back into machine mode
        run_cmd(csr_ecall, 12'h000, 32'h0, 1'b0, 1'b0, 32'h0, 1'b1, {sh_mtvec[31:2], 2'b00});
        read_expect(csr_addr_mcause, 32'd8 + 32'(sh_mode));
        sh_mode = mode_machine;
        read_expect(csr_addr_mscratch, sh_mscratch);

        // Enable the timer line and global interrupts, then make it pending
        run_cmd(csr_w, csr_addr_mie, 32'h0000_0080, 1'b0, 1'b1, 32'h0, 1'b0, 32'h0);
        run_cmd(csr_w, csr_addr_mstatus, 32'h0000_0008, 1'b0, 1'b1, 32'h0, 1'b0, 32'h0);
        mtime <= 64'd200;
        clear_checks;
        waited = 0;
        @(negedge clk);
        while (!stall_may_interrupt && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        if (!stall_may_interrupt) begin
            other_count++;
            $display("stall_may_interrupt never rose with the timer pending and enabled");
        end

        // Trap taken, the write offered in the same slot is dropped
        v = draw(30);
        pc_v = {v[29:0], 2'b00};
        @(posedge clk);
        fetch_pc        <= pc_v;
        interrupt_ready <= 1'b1;
        cmd             <= csr_w;
        imm_i           <= {20'h0, csr_addr_mscratch};
        op1_data        <= draw(32);
        check_stall     <= 1'b1;
        exp_stall       <= 1'b1;
        @(posedge clk);
        interrupt_ready <= 1'b0;
        cmd             <= csr_x;
        check_rd        <= 1'b1;
        exp_rd          <= 32'h0;
        check_iss       <= 1'b1;
        exp_iss         <= csr_ecall;
        check_tv        <= 1'b1;
        exp_tv          <= {sh_mtvec[31:2], 2'b00} + 32'd28;
        exp_stall       <= 1'b0;

        read_expect(csr_addr_mcause, 32'h8000_0007);
        read_expect(csr_addr_mepc, pc_v);
        // mie cleared, mpie set, mpp back to machine
        read_expect(csr_addr_mstatus, 32'h0000_1880);
        read_expect(csr_addr_mscratch, sh_mscratch);
        clear_checks;
        @(posedge clk);

        $display("Errors: %0d mismatch, %0d other, %0d bound assertion",
                 mismatch_count, other_count, dut_i.assertions_i.fail_count);
        if (mismatch_count + other_count + dut_i.assertions_i.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- csr_unit.f
source/csr_pkg.sv
source/csr_state_if.sv
source/csr_setup_if.sv
source/csr_access.sv
source/csr_setup_regs.sv
source/csr_trap_ctrl.sv
source/csr_unit.sv
sim/tb_clock.sv
sim/csr_unit_assertions.sv
sim/csr_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module csr_unit_tb -f csr_unit.f

status=0
./obj_dir/Vcsr_unit_tb +verilator+error+limit+100 > run.log 2>&1 || status=$?
cat run.log

if grep -q "test failed" run.log || [ "$status" -ne 0 ]; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation ok"
